/* design/bitmem_pkg.sv */
/*
 * shared widths, opcode enum and the structs that travel between
 * the command decoder, the bit-masked RAM and the response stage
 */
`default_nettype none

package bitmem_pkg;

  // data word width, fixed here because the structs depend on it
  localparam int unsigned bitmem_width = 32;

  // address width, enough for 64 words
  localparam int unsigned bitmem_addr_w = 6;

  typedef logic [bitmem_width-1:0]  word_t;
  typedef logic [bitmem_addr_w-1:0] addr_t;

  // command opcodes
  typedef enum logic [1:0] {
    OP_READ  = 2'b00,
    OP_WRITE = 2'b01,
    OP_SET   = 2'b10,
    OP_CLR   = 2'b11
  } cmd_op_e;

  // command as presented on the input port
  // mask is only looked at by OP_WRITE
  typedef struct packed {
    cmd_op_e op;
    addr_t   addr;
    word_t   data;
    word_t   mask;
  } cmd_t;

  // one access to the single-port RAM
  typedef struct packed {
    logic  v;
    logic  w;
    addr_t addr;
    word_t data;
    word_t w_mask;
  } mem_req_t;

  // read response payload
  typedef struct packed {
    word_t data;
  } resp_t;

endpackage

`default_nettype wire

/* design/bitmem_cmd_decode.sv */
/*
 * command decoder: range check against the word count and translation
 * of read, write, set and clear into one registered bit-masked RAM access
 */
`timescale 1ns/1ps
`default_nettype none

module bitmem_cmd_decode
#(
  parameter int unsigned els_p = 48
)
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cmd_v_i,
  input  bitmem_pkg::cmd_t     cmd_i,
  output bitmem_pkg::mem_req_t req_o,
  output logic                 err_o
);

  import bitmem_pkg::*;

  // one bit wider than the address so that a full 64-word array still fits
  localparam logic [bitmem_addr_w:0] els_lp = els_p[bitmem_addr_w:0];

  logic  in_range;
  logic  acc_v;
  logic  bad_addr;
  logic  nxt_w;
  word_t nxt_data;
  word_t nxt_mask;

  logic  req_v_r;
  logic  req_w_r;
  logic  err_r;
  addr_t req_addr_r;
  word_t req_data_r;
  word_t req_mask_r;

  assign in_range = ({1'b0, cmd_i.addr} < els_lp);

  // out-of-range commands never reach the RAM
  assign acc_v    = cmd_v_i & in_range;
  assign bad_addr = cmd_v_i & ~in_range;

  // opcode to write enable, write data and bit mask
  always_comb
  begin
    nxt_w    = 1'b1;
    nxt_data = cmd_i.data;
    nxt_mask = '0;
    case (cmd_i.op)
      OP_READ:
      begin
        nxt_w = 1'b0;
      end
      OP_WRITE:
      begin
        nxt_mask = cmd_i.mask;
      end
      // set and clear use the data field as the bit select
      OP_SET:
      begin
        nxt_data = '1;
        nxt_mask = cmd_i.data;
      end
      OP_CLR:
      begin
        nxt_data = '0;
        nxt_mask = cmd_i.data;
      end
      default:
      begin
        nxt_w = 1'b0;
      end
    endcase
  end

  // control state
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      req_v_r <= 1'b0;
      req_w_r <= 1'b0;
      err_r   <= 1'b0;
    end
    else
    begin
      req_v_r <= acc_v;
      req_w_r <= acc_v & nxt_w;
      err_r   <= bad_addr;
    end
  end

  // payload, only loaded for a real access
  always_ff @(posedge clk_i)
  begin
    if (acc_v)
    begin
      req_addr_r <= cmd_i.addr;
      req_data_r <= nxt_data;
      req_mask_r <= nxt_mask;
    end
  end

  assign req_o = '{
    v:      req_v_r,
    w:      req_w_r,
    addr:   req_addr_r,
    data:   req_data_r,
    w_mask: req_mask_r
  };

  assign err_o = err_r;

endmodule

`default_nettype wire

/* design/mem_1rw_sync_mask_write_bit.sv */
/*
 * synchronous single-port RAM with a per-bit write mask,
 * one read or one write per cycle, registered read data
 */
`timescale 1ns/1ps
`default_nettype none

module mem_1rw_sync_mask_write_bit
#(
  parameter int unsigned els_p = 48
)
(
  input  logic                 clk_i,
  input  bitmem_pkg::mem_req_t req_i,
  output bitmem_pkg::word_t    data_o
);

  import bitmem_pkg::*;

  // storage, contents are undefined after power up
  word_t mem_r [els_p];

  word_t data_r;
  logic  wr_en;
  logic  rd_en;

  // single port, so read and write are mutually exclusive
  assign wr_en = req_i.v & req_i.w;
  assign rd_en = req_i.v & ~req_i.w;

  // bit-masked write
  // only bits with a one in w_mask take the new data
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < bitmem_width; i++)
      begin
        if (req_i.w_mask[i])
        begin
          mem_r[req_i.addr][i] <= req_i.data[i];
        end
      end
    end
  end

  // synchronous read
  // output register holds its value between reads
  always_ff @(posedge clk_i)
  begin
    if (rd_en)
    begin
      data_r <= mem_r[req_i.addr];
    end
  end

  assign data_o = data_r;

endmodule

`default_nettype wire

/* design/bitmem_resp.sv */
/*
 * response stage: read-pending flag matched to the RAM latency
 * and a registered read response with a one-cycle valid pulse
 */
`timescale 1ns/1ps
`default_nettype none

module bitmem_resp
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  bitmem_pkg::mem_req_t req_i,
  input  bitmem_pkg::word_t    ram_data_i,
  output logic                 resp_v_o,
  output bitmem_pkg::resp_t    resp_o
);

  import bitmem_pkg::*;

  logic  rd_req;
  logic  rd_pend_r;
  logic  resp_v_r;
  resp_t resp_r;

  // a read access is presented to the RAM this cycle
  assign rd_req = req_i.v & ~req_i.w;

  // rd_pend_r lines up with the cycle in which RAM data is valid,
  // resp_v_r is the pulse one cycle later
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_pend_r <= 1'b0;
      resp_v_r  <= 1'b0;
    end
    else
    begin
      rd_pend_r <= rd_req;
      resp_v_r  <= rd_pend_r;
    end
  end

  // capture RAM output
  always_ff @(posedge clk_i)
  begin
    if (rd_pend_r)
    begin
      resp_r.data <= ram_data_i;
    end
  end

  assign resp_v_o = resp_v_r;
  assign resp_o   = resp_r;

endmodule

`default_nettype wire

/* design/bitmem_top.sv */
/*
 * bit-addressable scratchpad: command decoder, bit-masked single-port
 * RAM and read response stage, word count set here and passed down
 */
`timescale 1ns/1ps
`default_nettype none

module bitmem_top
#(
  parameter int unsigned els_p = 48
)
(
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cmd_v_i,
  input  bitmem_pkg::cmd_t  cmd_i,
  output logic              resp_v_o,
  output bitmem_pkg::resp_t resp_o,
  output logic              err_o
);

  import bitmem_pkg::*;

  // registered access from the decoder, seen by RAM and response stage
  mem_req_t req;

  // RAM read port output
  word_t    ram_data;

  // range check and opcode translation
  bitmem_cmd_decode
  #(
    .els_p   (els_p)
  )
  decode_i
  (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .cmd_v_i (cmd_v_i),
    .cmd_i   (cmd_i),
    .req_o   (req),
    .err_o   (err_o)
  );

  mem_1rw_sync_mask_write_bit
  #(
    .els_p   (els_p)
  )
  ram_i
  (
    .clk_i   (clk_i),
    .req_i   (req),
    .data_o  (ram_data)
  );

  // read data comes back two cycles after the command is sampled
  bitmem_resp resp_i
  (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req),
    .ram_data_i (ram_data),
    .resp_v_o   (resp_v_o),
    .resp_o     (resp_o)
  );

endmodule

`default_nettype wire

/* dv/bitmem_chk.sv */
/*
 * bound assertions on the scratchpad ports: read and error latency,
 * no response without a command, quiet outputs after reset
 */
`timescale 1ns/1ps
`default_nettype none

module bitmem_chk
#(
  parameter int unsigned els_p = 48
)
(
  input logic             clk_i,
  input logic             rst_i,
  input logic             cmd_v_i,
  input bitmem_pkg::cmd_t cmd_i,
  input logic             resp_v_i,
  input logic             err_i
);

  import bitmem_pkg::*;

  logic in_rng;
  logic rd_ok;
  logic bad;
  logic seen_cmd_r;
  int   fail_cnt = 0;

  assign in_rng = (32'(cmd_i.addr) < els_p);
  assign rd_ok  = cmd_v_i & in_rng & (cmd_i.op == OP_READ);
  assign bad    = cmd_v_i & ~in_rng;

  // set by the first command sampled after reset
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      seen_cmd_r <= 1'b0;
    end
    else if (cmd_v_i)
    begin
      seen_cmd_r <= 1'b1;
    end
  end

  // response pulse is high in the cycle after the second edge past the read
  read_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_ok |-> ##3 resp_v_i)
  else
  begin
    fail_cnt++;
    $error("resp_v_o missing for an in-range read sampled three edges earlier");
  end

  // out-of-range command flagged one cycle later
  err_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    bad |-> ##1 err_i)
  else
  begin
    fail_cnt++;
    $error("err_o missing 1 cycle after an out-of-range command");
  end

  resp_has_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    resp_v_i |-> $past(rd_ok, 3))
  else
  begin
    fail_cnt++;
    $error("resp_v_o high without an in-range read sampled three edges earlier");
  end

  err_has_cmd: assert property (@(posedge clk_i) disable iff (rst_i)
    err_i |-> $past(bad, 1))
  else
  begin
    fail_cnt++;
    $error("err_o high without an out-of-range command 1 cycle earlier");
  end

  // outputs stay low from reset until the first command is sampled
  reset_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !seen_cmd_r |-> (!resp_v_i && !err_i))
  else
  begin
    fail_cnt++;
    $error("resp_v_o or err_o high after reset before any command");
  end

endmodule

`default_nettype wire

/* dv/bitmem_tb.sv */
/*
 * testbench for the bit-addressable scratchpad: clock, reset, seeded
 * random commands, shadow memory and read data checks
 */
`timescale 1ns/1ps
`default_nettype none

module bitmem_tb;

  import bitmem_pkg::*;

  localparam int els_lp = 48;
  localparam int tmo_lp = 50;

  logic  clk = 1'b0;
  logic  rst;
  logic  cmd_v;
  cmd_t  cmd;
  logic  resp_v;
  resp_t resp;
  logic  err;

  // reference model of the RAM contents and the reads still in flight
  word_t shadow [64];
  word_t exp_q [$];
  string name_q [$];
  word_t exp_data;
  string exp_name;
  int    exp_err = 0;
  int    err_seen = 0;
  int    data_errs = 0;
  int    other_errs = 0;
  int    chk_errs = 0;

  bitmem_top #(.els_p(els_lp)) bitmem_top_i
  (
    .clk_i    (clk),
    .rst_i    (rst),
    .cmd_v_i  (cmd_v),
    .cmd_i    (cmd),
    .resp_v_o (resp_v),
    .resp_o   (resp),
    .err_o    (err)
  );

  bind bitmem_top bitmem_chk #(.els_p(els_p)) chk_i
  (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cmd_v_i  (cmd_v_i),
    .cmd_i    (cmd_i),
    .resp_v_i (resp_v_o),
    .err_i    (err_o)
  );

  always #10 clk = ~clk;

  // drive one command and update the model in command order
  task automatic send_cmd(input cmd_op_e op, input addr_t addr, input word_t data,
                          input word_t mask, input string name);
    @(posedge clk);
    cmd_v <= 1'b1;
    cmd   <= '{op: op, addr: addr, data: data, mask: mask};
    if (int'(addr) >= els_lp)
    begin
      exp_err++;
    end
    else
    begin
      case (op)
        OP_READ:
        begin
          exp_q.push_back(shadow[addr]);
          name_q.push_back(name);
        end
        OP_WRITE: shadow[addr] = (shadow[addr] & ~mask) | (data & mask);
        OP_SET:   shadow[addr] = shadow[addr] | data;
        OP_CLR:   shadow[addr] = shadow[addr] & ~data;
        default:  ;
      endcase
    end
  endtask

  // stop issuing and wait until every read and error has come back
  task automatic drain(input string what);
    int i;
    @(posedge clk);
    cmd_v <= 1'b0;
    i = 0;
    while ((exp_q.size() != 0 || err_seen != exp_err) && i < tmo_lp)
    begin
      @(posedge clk);
      i++;
    end
    if (exp_q.size() != 0 || err_seen != exp_err)
    begin
      $display("timeout in %s: %0d reads still outstanding, %0d of %0d errors seen",
               what, exp_q.size(), err_seen, exp_err);
      other_errs++;
    end
  endtask

  function automatic addr_t rand_addr();
    return addr_t'($urandom_range(els_lp - 1, 0));
  endfunction

  // responses and error pulses, sampled on the clock edge
  always @(posedge clk)
  begin
    if (!rst && err)
    begin
      err_seen++;
    end
    if (!rst && resp_v)
    begin
      if (exp_q.size() == 0)
      begin
        $display("read response arrived with no read outstanding");
        other_errs++;
      end
      else
      begin
        exp_data = exp_q.pop_front();
        exp_name = name_q.pop_front();
        assert (resp.data === exp_data)
        else
        begin
          $display("Error %s: expected %h actual %h", exp_name, exp_data, resp.data);
          data_errs++;
        end
      end
    end
  end

  initial
  begin
    addr_t a;
    void'($urandom(32'h9d84_994c));
    rst   = 1'b1;
    cmd_v = 1'b0;
    cmd   = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // a few quiet cycles, outputs have to stay low
    repeat (3) @(posedge clk);

    for (int i = 0; i < els_lp; i++)
    begin
      send_cmd(OP_WRITE, addr_t'(i), $urandom(), '1, "init");
    end
    drain("init");

    for (int i = 0; i < 8; i++)
    begin
      a = rand_addr();
      send_cmd(OP_WRITE, a, $urandom(), '1, "full_wr_rd");
      drain("full_wr_rd write");
      send_cmd(OP_READ, a, '0, '0, "full_wr_rd");
      drain("full_wr_rd read");
    end

    for (int i = 0; i < 12; i++)
    begin
      a = rand_addr();
      send_cmd(OP_WRITE, a, $urandom(), $urandom(), "mask_wr");
      send_cmd(OP_READ, a, '0, '0, "mask_wr");
      drain("mask_wr");
    end

    for (int i = 0; i < 8; i++)
    begin
      a = rand_addr();
      send_cmd(OP_SET, a, $urandom(), $urandom(), "set_bits");
      send_cmd(OP_READ, a, '0, '0, "set_bits");
      a = rand_addr();
      send_cmd(OP_CLR, a, $urandom(), $urandom(), "clr_bits");
      send_cmd(OP_READ, a, '0, '0, "clr_bits");
    end
    drain("set_clr");

    // write then read of the same word in the next cycle, then a read burst
    for (int i = 0; i < 6; i++)
    begin
      a = rand_addr();
      send_cmd(OP_WRITE, a, $urandom(), $urandom(), "b2b_wr_rd");
      send_cmd(OP_READ, a, '0, '0, "b2b_wr_rd");
    end
    for (int i = 0; i < 8; i++)
    begin
      send_cmd(OP_READ, addr_t'(i), '0, '0, "b2b_burst");
    end
    drain("back_to_back");

    for (int i = els_lp; i < 64; i++)
    begin
      send_cmd(cmd_op_e'(2'($urandom_range(3, 0))), addr_t'(i), $urandom(),
               $urandom(), "oor_cmd");
    end
    drain("oor_cmd");
    for (int i = 0; i < els_lp; i++)
    begin
      send_cmd(OP_READ, addr_t'(i), '0, '0, "oor_scan");
    end
    drain("oor_scan");

    chk_errs = bitmem_top_i.chk_i.fail_cnt;
    $display("errors: data %0d, other %0d, assertion %0d", data_errs, other_errs, chk_errs);
    if (data_errs + other_errs + chk_errs == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
design/bitmem_pkg.sv
design/bitmem_cmd_decode.sv
design/mem_1rw_sync_mask_write_bit.sv
design/bitmem_resp.sv
design/bitmem_top.sv
dv/bitmem_chk.sv
dv/bitmem_tb.sv

/* Makefile */
# Verilator build and run for the bit-addressable scratchpad

VERILATOR ?= verilator
TOP       ?= bitmem_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the simulation printed the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
	  exit 0; \
	else \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
